// File: Bender.yml
package:
  name: stepper_axis

sources:
  - files:
      - verilog/stepper_pkg.sv
      - verilog/motion_config.sv
      - verilog/step_count_calc.sv
      - verilog/ramp_profile.sv
      - verilog/step_pulse_gen.sv
      - verilog/stepper_axis_top.sv
  - target: test
    files:
      - testbench/stepper_checker.sv
      - testbench/tb_stepper_axis.sv

// File: flist.f
verilog/stepper_pkg.sv
verilog/motion_config.sv
verilog/step_count_calc.sv
verilog/ramp_profile.sv
verilog/step_pulse_gen.sv
verilog/stepper_axis_top.sv
testbench/stepper_checker.sv
testbench/tb_stepper_axis.sv

// File: testbench/stepper_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_checker (
  input  wire                         clk_i,
  input  wire                         rst_i,
  input  wire                         cfg_wr_i,
  input  wire stepper_pkg::cfg_addr_t cfg_addr_i,
  input  wire [31:0]                  cfg_data_i,
  input  wire                         move_i,
  input  wire stepper_pkg::angle_t    angle_i,
  input  wire                         step_i,
  input  wire                         dir_i,
  input  wire                         done_i,
  output int                          errors_o
);
  import stepper_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_PENDING, M_RUN} model_phase_t;

  motion_cfg_t  m_cfg;
  model_phase_t phase;
  logic         exp_done;
  logic         exp_dir;
  logic         exp_step;
  longint       cyc;
  longint       step_at;
  step_count_t  total;
  step_count_t  steps_done;
  step_count_t  pulses;
  period_t      cur_period;

  // Whole steps for an angle with the fraction of the Q16.16 product dropped
  function automatic step_count_t steps_for(angle_t angle, scale_t scale);
    logic [63:0] mag;
    mag = (angle < 0) ? -longint'(angle) : longint'(angle);
    return step_count_t'((mag * scale) >> FRAC_BITS);
  endfunction

  // Speed up while in the first half of the move, slow down after it
  function automatic period_t next_period(period_t prev, step_count_t k, step_count_t tot,
                                          motion_cfg_t c);
    longint p;
    if (2 * longint'(k) <= longint'(tot)) begin
      p = longint'(prev) - longint'(c.accel);
      if (p < longint'(c.min_period)) begin
        p = c.min_period;
      end
    end else begin
      p = longint'(prev) + longint'(c.accel);
      if (p > longint'(c.start_period)) begin
        p = c.start_period;
      end
    end
    return period_t'(p);
  endfunction

  task automatic compare_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s expected=%0d actual=%0d",
               $time, name, expected, actual);
      errors_o++;
    end
  endtask

  initial begin
    errors_o = 0;
    cyc      = 0;
  end

  // Outputs are sampled at the rising edge, before the DUT registers update
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (rst_i) begin
      m_cfg.scale        = RESET_SCALE;
      m_cfg.start_period = RESET_START_PERIOD;
      m_cfg.min_period   = RESET_MIN_PERIOD;
      m_cfg.accel        = RESET_ACCEL;
      phase    = M_IDLE;
      exp_done = 1'b1;
      exp_dir  = 1'b0;
      exp_step = 1'b0;
    end else begin
      compare_value("step_o", exp_step, step_i);
      compare_value("done_o", exp_done, done_i);
      compare_value("dir_o", exp_dir, dir_i);
      if ((phase == M_RUN) && step_i) begin
        pulses++;
      end
      case (phase)
        M_IDLE: begin
          if (move_i) begin
            total   = steps_for(angle_i, m_cfg.scale);
            exp_dir = (angle_i < 0);
            phase   = M_PENDING;
          end
        end
        M_PENDING: begin
          // Zero steps leaves the axis idle with done high
          if (total == 0) begin
            phase = M_IDLE;
          end else begin
            phase      = M_RUN;
            exp_done   = 1'b0;
            cur_period = m_cfg.start_period;
            steps_done = 0;
            pulses     = 0;
            step_at    = cyc + 1 + cur_period;
          end
        end
        default: begin
          if (cyc == step_at) begin
            steps_done++;
            if (steps_done == total) begin
              exp_done = 1'b1;
              phase    = M_IDLE;
              compare_value("step_o pulse count", total, pulses);
            end else begin
              cur_period = next_period(cur_period, steps_done, total, m_cfg);
              step_at    = cyc + cur_period;
            end
          end
        end
      endcase
      exp_step = (phase == M_RUN) && (cyc + 1 == step_at);
      if (cfg_wr_i) begin
        case (cfg_addr_i)
          CFG_SCALE:        m_cfg.scale        = cfg_data_i;
          CFG_START_PERIOD: m_cfg.start_period = cfg_data_i[23:0];
          CFG_MIN_PERIOD:   m_cfg.min_period   = cfg_data_i[23:0];
          default:          m_cfg.accel        = cfg_data_i[23:0];
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_stepper_axis.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stepper_axis;
  import stepper_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 5;
  localparam int NUM_TESTS  = 6;
  localparam int MAX_MOVES  = 16;
  // Angle of the strobe that must be dropped while the axis is busy
  // Its sign is opposite to the running move so a taken strobe shows on dir_o
  localparam int BUSY_ANGLE = -300;

  logic        clk_i;
  logic        rst_i;
  logic        cfg_wr_i;
  cfg_addr_t   cfg_addr_i;
  logic [31:0] cfg_data_i;
  logic        move_i;
  angle_t      angle_i;
  wire         step_o;
  wire         dir_o;
  wire         done_o;
  int          errors;

  int          move_test [MAX_MOVES];
  angle_t      move_angle [MAX_MOVES];
  motion_cfg_t move_cfg [MAX_MOVES];
  logic        move_busy_strobe [MAX_MOVES];
  int          num_moves;
  motion_cfg_t cur_cfg;
  logic [31:0] lcg_state;
  longint      budget_ns;
  logic        budget_ready;
  int          failed_tests;
  int          errors_before;

  stepper_axis_top UUT (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_wr_i   (cfg_wr_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .move_i     (move_i),
    .angle_i    (angle_i),
    .step_o     (step_o),
    .dir_o      (dir_o),
    .done_o     (done_o)
  );

  stepper_checker u_checker (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_wr_i   (cfg_wr_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .move_i     (move_i),
    .angle_i    (angle_i),
    .step_i     (step_o),
    .dir_i      (dir_o),
    .done_i     (done_o),
    .errors_o   (errors)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(int lo, int hi);
    return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
  endfunction

  function automatic angle_t random_angle();
    int mag;
    mag = rand_range(0, 400);
    return (rand_range(0, 1) == 1) ? -mag : mag;
  endfunction

  function automatic string test_name(int id);
    case (id)
      1:       return "reset default moves";
      2:       return "ramp profile";
      3:       return "done timing";
      4:       return "zero step moves";
      5:       return "strobe while busy";
      default: return "random configurations";
    endcase
  endfunction

  task automatic add_move(int test_id, angle_t angle, motion_cfg_t cfg, logic busy_strobe);
    move_test[num_moves]        = test_id;
    move_angle[num_moves]       = angle;
    move_cfg[num_moves]         = cfg;
    move_busy_strobe[num_moves] = busy_strobe;
    num_moves++;
  endtask

  task automatic build_moves();
    motion_cfg_t dflt;
    motion_cfg_t cfg;
    dflt = '{RESET_SCALE, RESET_START_PERIOD, RESET_MIN_PERIOD, RESET_ACCEL};
    for (int i = 0; i < 3; i++) begin
      add_move(1, random_angle(), dflt, 1'b0);
    end
    add_move(2, 60, dflt, 1'b0);
    add_move(3, -7, dflt, 1'b0);
    add_move(4, 0, dflt, 1'b0);
    // A quarter step per unit, so three units truncate to nothing
    cfg       = dflt;
    cfg.scale = 32'h0000_4000;
    add_move(4, -3, cfg, 1'b0);
    add_move(5, 25, dflt, 1'b1);
    for (int i = 0; i < 4; i++) begin
      cfg.scale        = scale_t'(rand_range(32'h2000, 32'h2ffff));
      cfg.start_period = period_t'(rand_range(40, 300));
      cfg.min_period   = period_t'(rand_range(2, cfg.start_period / 2));
      cfg.accel        = period_t'(rand_range(20, 120));
      add_move(6, random_angle(), cfg, 1'b0);
    end
  endtask

  task automatic write_reg(cfg_addr_t addr, logic [31:0] data);
    @(negedge clk_i);
    cfg_wr_i   = 1'b1;
    cfg_addr_i = addr;
    cfg_data_i = data;
    @(negedge clk_i);
    cfg_wr_i = 1'b0;
  endtask

  task automatic run_move(int idx);
    motion_cfg_t c;
    c = move_cfg[idx];
    if (c.scale != cur_cfg.scale) write_reg(CFG_SCALE, c.scale);
    if (c.start_period != cur_cfg.start_period) write_reg(CFG_START_PERIOD, c.start_period);
    if (c.min_period != cur_cfg.min_period) write_reg(CFG_MIN_PERIOD, c.min_period);
    if (c.accel != cur_cfg.accel) write_reg(CFG_ACCEL, c.accel);
    cur_cfg = c;
    @(negedge clk_i);
    move_i  = 1'b1;
    angle_i = move_angle[idx];
    @(negedge clk_i);
    move_i = 1'b0;
    // By now done_o has fallen if the move has any steps
    repeat (2) @(negedge clk_i);
    if (move_busy_strobe[idx] && !done_o) begin
      move_i  = 1'b1;
      angle_i = BUSY_ANGLE;
      @(negedge clk_i);
      move_i = 1'b0;
    end
    while (!done_o) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
  endtask

  initial begin
    longint mag;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    cfg_wr_i     = 1'b0;
    cfg_addr_i   = '0;
    cfg_data_i   = '0;
    move_i       = 1'b0;
    angle_i      = '0;
    lcg_state    = 32'd4;
    num_moves    = 0;
    failed_tests = 0;
    budget_ready = 1'b0;
    build_moves();
    // Worst case per move is every step at the start period
    budget_ns = longint'(RST_CYCLES + 200) * CLK_PERIOD;
    for (int i = 0; i < num_moves; i++) begin
      mag = (move_angle[i] < 0) ? -longint'(move_angle[i]) : longint'(move_angle[i]);
      budget_ns += (longint'(move_cfg[i].start_period) *
                    ((mag * move_cfg[i].scale) >> FRAC_BITS) + 60) * CLK_PERIOD;
    end
    budget_ready = 1'b1;
    cur_cfg = '{RESET_SCALE, RESET_START_PERIOD, RESET_MIN_PERIOD, RESET_ACCEL};
    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      errors_before = errors;
      for (int i = 0; i < num_moves; i++) begin
        if (move_test[i] == t) begin
          run_move(i);
        end
      end
      if (errors == errors_before) begin
        $display("test %0d %s: pass", t, test_name(t));
      end else begin
        failed_tests++;
        $display("test %0d %s: fail, %0d mismatches", t, test_name(t), errors - errors_before);
      end
    end
    $display("tests %0d, failed %0d, mismatches %0d", NUM_TESTS, failed_tests, errors);
    if (failed_tests == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (budget_ready);
    #(budget_ns);
    $display("Timeout: the moves did not finish within %0d ns", budget_ns);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/motion_config.sv
`timescale 1ns/1ps
`default_nettype none

module motion_config (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      cfg_wr_i,
  input  wire stepper_pkg::cfg_addr_t   cfg_addr_i,
  input  wire [31:0]               cfg_data_i,
  output stepper_pkg::motion_cfg_t cfg_o
);
  import stepper_pkg::*;

  motion_cfg_t cfg_q;

  // Period fields are only 24 bits wide
  period_t data_period;

  assign data_period = cfg_data_i[23:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_q.scale        <= RESET_SCALE;
      cfg_q.start_period <= RESET_START_PERIOD;
      cfg_q.min_period   <= RESET_MIN_PERIOD;
      cfg_q.accel        <= RESET_ACCEL;
    end else if (cfg_wr_i) begin
      unique case (cfg_addr_i)
        CFG_SCALE: begin
          cfg_q.scale <= cfg_data_i;
        end
        CFG_START_PERIOD: begin
          cfg_q.start_period <= data_period;
        end
        CFG_MIN_PERIOD: begin
          cfg_q.min_period <= data_period;
        end
        CFG_ACCEL: begin
          cfg_q.accel <= data_period;
        end
      endcase
    end
  end

  // New values reach the profile logic one cycle after the strobe
  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: verilog/ramp_profile.sv
`timescale 1ns/1ps
`default_nettype none

module ramp_profile (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire stepper_pkg::motion_cfg_t cfg_i,
  input  wire stepper_pkg::step_count_t count_i,
  input  wire                          count_valid_i,
  input  wire                          step_done_i,
  output logic                         load_o,
  output stepper_pkg::period_t         period_o,
  output logic                         busy_o,
  output logic                         done_o
);
  import stepper_pkg::*;

  profile_state_t state_q;
  step_count_t    steps_done_q;
  step_count_t    total_q;
  period_t        period_q;
  period_t        next_period;
  logic           kick_q;
  logic           done_q;

  logic [32:0] step_k;
  logic [33:0] twice_k;
  logic        last_step;
  logic        slow_down;
  logic [24:0] dec_diff;
  logic [24:0] inc_sum;

  // Number of the step that completes on step_done_i, counted from 1
  assign step_k    = {1'b0, steps_done_q} + 33'd1;
  assign twice_k   = {step_k, 1'b0};
  assign last_step = (step_k == {1'b0, total_q});

  // Once past the midpoint the ramp only goes down
  assign slow_down = (state_q == DECEL) || (twice_k > {2'b00, total_q});

  assign dec_diff = {1'b0, period_q} - {1'b0, cfg_i.accel};
  assign inc_sum  = {1'b0, period_q} + {1'b0, cfg_i.accel};

  always_comb begin
    if (slow_down) begin
      // Grow back towards the start period
      if (inc_sum > {1'b0, cfg_i.start_period}) begin
        next_period = cfg_i.start_period;
      end else begin
        next_period = inc_sum[23:0];
      end
    end else begin
      // Shrink, but never below the minimum; also catches underflow
      if (dec_diff[24] || (dec_diff[23:0] < cfg_i.min_period)) begin
        next_period = cfg_i.min_period;
      end else begin
        next_period = dec_diff[23:0];
      end
    end
  end

  // First load comes from the kick register, later ones ride on step_done
  assign load_o   = kick_q || (step_done_i && (state_q != IDLE) && !last_step);
  assign period_o = kick_q ? period_q : next_period;
  assign busy_o   = (state_q != IDLE);
  assign done_o   = done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= IDLE;
      steps_done_q <= '0;
      kick_q       <= 1'b0;
      done_q       <= 1'b1;
    end else begin
      kick_q <= 1'b0;
      unique case (state_q)
        IDLE: begin
          // A move of zero steps is dropped here
          if (count_valid_i && (count_i != '0)) begin
            steps_done_q <= '0;
            kick_q       <= 1'b1;
            done_q       <= 1'b0;
            state_q      <= ACCEL;
          end
        end
        ACCEL, DECEL: begin
          if (step_done_i) begin
            steps_done_q <= step_k[31:0];
            if (last_step) begin
              done_q  <= 1'b1;
              state_q <= IDLE;
            end else if (slow_down) begin
              state_q <= DECEL;
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Move length and current period
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && count_valid_i) begin
      total_q  <= count_i;
      period_q <= cfg_i.start_period;
    end else if (step_done_i && (state_q != IDLE)) begin
      period_q <= next_period;
    end
  end

endmodule

`default_nettype wire

// File: verilog/step_count_calc.sv
`timescale 1ns/1ps
`default_nettype none

module step_count_calc (
  input  wire                       clk_i,
  input  wire                       rst_i,
  input  wire                       move_i,
  input  wire stepper_pkg::angle_t  angle_i,
  input  wire stepper_pkg::scale_t  scale_i,
  input  wire                       busy_i,
  output stepper_pkg::step_count_t  count_o,
  output logic                      count_valid_o,
  output logic                      dir_o
);
  import stepper_pkg::*;

  logic [31:0] angle_mag;
  logic [63:0] product;
  logic        accept;

  // Magnitude of the angle; -2^31 still fits as unsigned
  assign angle_mag = angle_i[31] ? 32'(-angle_i) : 32'(angle_i);

  assign product = 64'(angle_mag) * 64'(scale_i);

  // Drop strobes while a move runs or one is already on its way
  assign accept = move_i && !busy_i && !count_valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_valid_o <= 1'b0;
      dir_o         <= 1'b0;
    end else begin
      count_valid_o <= accept;
      if (accept) begin
        dir_o <= angle_i[31];
      end
    end
  end

  // Integer part of the Q16.16 product with the fraction truncated
  always_ff @(posedge clk_i) begin
    if (accept) begin
      count_o <= product[FRAC_BITS +: 32];
    end
  end

endmodule

`default_nettype wire

// File: verilog/step_pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

module step_pulse_gen (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire                        load_i,
  input  wire stepper_pkg::period_t  period_i,
  output logic                       step_o,
  output logic                       step_done_o
);
  import stepper_pkg::*;

  period_t cnt_q;
  logic    armed_q;
  logic    fire;

  // A load at cycle L gives step_o at cycle L + period
  always_comb begin
    fire = 1'b0;
    if (load_i) begin
      // Periods of 0 or 1 fire on the next cycle
      fire = (period_i <= 24'd1);
    end else if (armed_q) begin
      fire = (cnt_q == 24'd1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      armed_q     <= 1'b0;
      step_o      <= 1'b0;
      step_done_o <= 1'b0;
    end else begin
      step_o      <= fire;
      step_done_o <= fire;
      if (load_i) begin
        armed_q <= !fire;
      end else if (fire) begin
        // Stay idle until the next load
        armed_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      cnt_q <= period_i - 24'd1;
    end else if (armed_q) begin
      cnt_q <= cnt_q - 24'd1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/stepper_axis_top.sv
`timescale 1ns/1ps
`default_nettype none

module stepper_axis_top (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          cfg_wr_i,
  input  wire stepper_pkg::cfg_addr_t  cfg_addr_i,
  input  wire [31:0]                   cfg_data_i,
  input  wire                          move_i,
  input  wire stepper_pkg::angle_t     angle_i,
  output wire                          step_o,
  output wire                          dir_o,
  output wire                          done_o
);
  import stepper_pkg::*;

  motion_cfg_t cfg;
  step_count_t count;
  logic        count_valid;
  logic        busy;
  logic        load;
  period_t     period;
  logic        step_done;

  motion_config u_motion_config (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_wr_i   (cfg_wr_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_data_i (cfg_data_i),
    .cfg_o      (cfg)
  );

  step_count_calc u_step_count_calc (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .move_i        (move_i),
    .angle_i       (angle_i),
    .scale_i       (cfg.scale),
    .busy_i        (busy),
    .count_o       (count),
    .count_valid_o (count_valid),
    .dir_o         (dir_o)
  );

  ramp_profile u_ramp_profile (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cfg_i         (cfg),
    .count_i       (count),
    .count_valid_i (count_valid),
    .step_done_i   (step_done),
    .load_o        (load),
    .period_o      (period),
    .busy_o        (busy),
    .done_o        (done_o)
  );

  step_pulse_gen u_step_pulse_gen (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .load_i      (load),
    .period_i    (period),
    .step_o      (step_o),
    .step_done_o (step_done)
  );

endmodule

`default_nettype wire

// File: verilog/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Q16.16 scale
  localparam int FRAC_BITS = 16;

  typedef logic signed [31:0] angle_t;
  typedef logic [31:0]        scale_t;
  typedef logic [31:0]        step_count_t;
  typedef logic [23:0]        period_t;
  typedef logic [1:0]         cfg_addr_t;

  // Register map
  localparam cfg_addr_t CFG_SCALE        = 2'd0;
  localparam cfg_addr_t CFG_START_PERIOD = 2'd1;
  localparam cfg_addr_t CFG_MIN_PERIOD   = 2'd2;
  localparam cfg_addr_t CFG_ACCEL        = 2'd3;

  // Reset values with a scale of 1.0 step per angle unit
  localparam scale_t  RESET_SCALE        = 32'h0001_0000;
  localparam period_t RESET_START_PERIOD = 24'd200;
  localparam period_t RESET_MIN_PERIOD   = 24'd20;
  localparam period_t RESET_ACCEL        = 24'd10;

  typedef struct packed {
    scale_t  scale;
    period_t start_period;
    period_t min_period;
    period_t accel;
  } motion_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCEL,
    DECEL
  } profile_state_t;

endpackage

`default_nettype wire
